//--- hw/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// ---------------------------------------------------------------------------
// core widths
// ---------------------------------------------------------------------------

// data and address width.
`define XLEN 32

// architectural integer registers, x0 included.
`define REG_COUNT 32

`endif

//--- hw/isaPkg.sv
package isaPkg;

	// major opcodes handled by the decoder. system/env is left out on purpose.
	typedef enum logic [6:0] {
		R_FORMAT       = 7'b0110011,
		I_COMP_FORMAT  = 7'b0010011,
		I_LOAD_FORMAT  = 7'b0000011,
		I_JALR_FORMAT  = 7'b1100111,
		S_FORMAT       = 7'b0100011,
		B_FORMAT       = 7'b1100011,
		J_FORMAT       = 7'b1101111,
		U_FORMAT_LUI   = 7'b0110111,
		U_FORMAT_AUIPC = 7'b0010111
	} opcodeT;

	// funct3 of the compute group.
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 of the branch group.
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam int F7_ALT_BIT = 5; // funct7 bit picking sub and sra.

	// ---------------------------------------------------------------------------
	// instruction formats, fields at their ISA bit positions
	// ---------------------------------------------------------------------------

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcodeT      opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcodeT     opcode;
	} sTypeT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		opcodeT     opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm31to12;
		logic [4:0]  rd;
		opcodeT      opcode;
	} uTypeT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		opcodeT     opcode;
	} jTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		sTypeT sType;
		bTypeT bType;
		uTypeT uType;
		jTypeT jType;
	} instructionT;

endpackage

//--- hw/controlPkg.sv
package controlPkg;

	// one datapath control line. the nine lines are
	// branch, memRead, memWrite, memToReg, aluSrc, regWrite, jump, jumpJalr, inAIsPc.
	typedef logic ctrlBitT;

	// coarse ALU class out of the main decoder.
	typedef enum logic [2:0] {
		ALU_R          = 3'd0,
		ALU_I_COMP     = 3'd1,
		ALU_LOAD_STORE = 3'd2,
		ALU_BRANCH     = 3'd3,
		ALU_J          = 3'd4,
		ALU_LUI        = 3'd5,
		ALU_AUIPC      = 3'd6
	} aluCntrlT;

	// operation seen by the execute stage.
	// bgeu reuses BR_GE, the unsigned compare comes from funct3.
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		PASS_B = 4'd10,
		BR_EQ  = 4'd11,
		BR_NE  = 4'd12,
		BR_LT  = 4'd13,
		BR_GE  = 4'd14,
		BR_LTU = 4'd15
	} aluOpT;

endpackage

//--- hw/mainControl.sv
`timescale 1ns/10ps

module mainControl
	import isaPkg::*;
	import controlPkg::*;
(
	input  opcodeT   opcode,
	output ctrlBitT  branch,
	output ctrlBitT  memRead,
	output ctrlBitT  memWrite,
	output ctrlBitT  memToReg,
	output ctrlBitT  aluSrc,
	output ctrlBitT  regWrite,
	output ctrlBitT  jump,
	output ctrlBitT  jumpJalr,
	output ctrlBitT  inAIsPc,
	output aluCntrlT aluCntrl
);

	always_comb begin
		branch   = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrc   = 1'b0;
		regWrite = 1'b0;
		jump     = 1'b0;
		jumpJalr = 1'b0;
		inAIsPc  = 1'b0;
		aluCntrl = ALU_R;

		case (opcode)
			R_FORMAT: begin
				regWrite = 1'b1;
			end
			I_COMP_FORMAT: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				aluCntrl = ALU_I_COMP;
			end
			I_LOAD_FORMAT: begin
				memRead  = 1'b1;
				memToReg = 1'b1; // writeback takes the load data.
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				aluCntrl = ALU_LOAD_STORE;
			end
			S_FORMAT: begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
				aluCntrl = ALU_LOAD_STORE;
			end
			B_FORMAT: begin
				branch   = 1'b1;
				aluCntrl = ALU_BRANCH;
			end
			J_FORMAT: begin
				jump     = 1'b1;
				regWrite = 1'b1; // link register.
				inAIsPc  = 1'b1;
				aluCntrl = ALU_J;
			end
			I_JALR_FORMAT: begin
				jumpJalr = 1'b1;
				regWrite = 1'b1;
				aluCntrl = ALU_J;
			end
			U_FORMAT_LUI: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				aluCntrl = ALU_LUI;
			end
			U_FORMAT_AUIPC: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				inAIsPc  = 1'b1;
				aluCntrl = ALU_AUIPC;
			end
			default: ; // illegal or system opcode, nothing is written.
		endcase
	end

endmodule

//--- hw/aluControl.sv
`timescale 1ns/10ps

module aluControl
	import isaPkg::*;
	import controlPkg::*;
(
	input  aluCntrlT   aluCntrl,
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,
	output aluOpT      aluOp
);

	logic  altOp;
	aluOpT arithOp;
	aluOpT branchOp;

	// immediate forms read funct7 only for shifts, so addi never turns into sub.
	assign altOp = funct7[F7_ALT_BIT] && (aluCntrl == ALU_R || funct3 == F3_SRL_SRA);

	always_comb begin
		arithOp = ADD;
		case (funct3)
			F3_ADD_SUB: arithOp = altOp ? SUB : ADD;
			F3_SLL:     arithOp = SLL;
			F3_SLT:     arithOp = SLT;
			F3_SLTU:    arithOp = SLTU;
			F3_XOR:     arithOp = XOR;
			F3_SRL_SRA: arithOp = altOp ? SRA : SRL;
			F3_OR:      arithOp = OR;
			F3_AND:     arithOp = AND;
			default:    arithOp = ADD;
		endcase
	end

	always_comb begin
		case (funct3)
			F3_BNE:  branchOp = BR_NE;
			F3_BLT:  branchOp = BR_LT;
			F3_BGE:  branchOp = BR_GE;
			F3_BLTU: branchOp = BR_LTU;
			F3_BGEU: branchOp = BR_GE; // unsigned, told apart by funct3.
			F3_BEQ:  branchOp = BR_EQ;
			default: branchOp = BR_EQ;
		endcase
	end

	always_comb begin
		case (aluCntrl)
			ALU_R, ALU_I_COMP: aluOp = arithOp;
			ALU_BRANCH:        aluOp = branchOp;
			ALU_LUI:           aluOp = PASS_B;
			default:           aluOp = ADD; // address or link arithmetic.
		endcase
	end

endmodule

//--- hw/immGen.sv
`timescale 1ns/10ps
`include "riscv_settings.svh"

module immGen
	import isaPkg::*;
(
	input  instructionT      instruction,
	output logic [`XLEN-1:0] imm
);

	always_comb begin
		case (instruction.rType.opcode)
			I_COMP_FORMAT, I_LOAD_FORMAT, I_JALR_FORMAT: begin
				imm = {{(`XLEN-12){instruction.iType.imm[11]}}, instruction.iType.imm};
			end
			S_FORMAT: begin
				imm = {{(`XLEN-12){instruction.sType.immHi[6]}},
					instruction.sType.immHi, instruction.sType.immLo};
			end
			B_FORMAT: begin // halfword offset.
				imm = {{(`XLEN-12){instruction.bType.imm12}}, instruction.bType.imm11,
					instruction.bType.imm10to5, instruction.bType.imm4to1, 1'b0};
			end
			U_FORMAT_LUI, U_FORMAT_AUIPC: begin
				imm = {instruction.uType.imm31to12, 12'b0};
			end
			J_FORMAT: begin
				imm = {{(`XLEN-20){instruction.jType.imm20}}, instruction.jType.imm19to12,
					instruction.jType.imm11, instruction.jType.imm10to1, 1'b0};
			end
			default: begin
				imm = '0; // r-type and illegal words carry no immediate.
			end
		endcase
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps
`include "riscv_settings.svh"

module regFile (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [$clog2(`REG_COUNT)-1:0] rs1,
	input  logic [$clog2(`REG_COUNT)-1:0] rs2,
	output logic [`XLEN-1:0]             rs1Data,
	output logic [`XLEN-1:0]             rs2Data,
	input  logic                         wbEnable,
	input  logic [$clog2(`REG_COUNT)-1:0] wbAddr,
	input  logic [`XLEN-1:0]             wbData
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// x0 is hardwired, a pending writeback wins over the stored word.
	function automatic logic [`XLEN-1:0] readPort(input logic [$clog2(`REG_COUNT)-1:0] addr);
		if (addr == '0)
			return '0;
		if (wbEnable && wbAddr == addr)
			return wbData;
		return regs[addr];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbEnable && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

endmodule

//--- hw/idExRegister.sv
`timescale 1ns/10ps
`include "riscv_settings.svh"

module idExRegister
	import controlPkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         stall,
	input  logic                         flush,
	input  logic                         instValid,
	input  ctrlBitT                      branch,
	input  ctrlBitT                      memRead,
	input  ctrlBitT                      memWrite,
	input  ctrlBitT                      memToReg,
	input  ctrlBitT                      aluSrc,
	input  ctrlBitT                      regWrite,
	input  ctrlBitT                      jump,
	input  ctrlBitT                      jumpJalr,
	input  ctrlBitT                      inAIsPc,
	input  aluOpT                        aluOp,
	input  logic [`XLEN-1:0]             pc,
	input  logic [`XLEN-1:0]             rs1Data,
	input  logic [`XLEN-1:0]             rs2Data,
	input  logic [`XLEN-1:0]             imm,
	input  logic [$clog2(`REG_COUNT)-1:0] rd,
	input  logic [2:0]                   funct3,
	output logic                         exValid,
	output ctrlBitT                      exBranch,
	output ctrlBitT                      exMemRead,
	output ctrlBitT                      exMemWrite,
	output ctrlBitT                      exMemToReg,
	output ctrlBitT                      exAluSrc,
	output ctrlBitT                      exRegWrite,
	output ctrlBitT                      exJump,
	output ctrlBitT                      exJumpJalr,
	output ctrlBitT                      exInAIsPc,
	output aluOpT                        exAluOp,
	output logic [`XLEN-1:0]             exPc,
	output logic [`XLEN-1:0]             exRs1Data,
	output logic [`XLEN-1:0]             exRs2Data,
	output logic [`XLEN-1:0]             exImm,
	output logic [$clog2(`REG_COUNT)-1:0] exRd,
	output logic [2:0]                   exFunct3
);

	// ---------------------------------------------------------------------------
	// control half, a flush or an invalid slot leaves a bubble
	// ---------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			exValid    <= 1'b0;
			exBranch   <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exAluSrc   <= 1'b0;
			exRegWrite <= 1'b0;
			exJump     <= 1'b0;
			exJumpJalr <= 1'b0;
			exInAIsPc  <= 1'b0;
		end else if (!stall) begin
			exValid    <= instValid;
			exBranch   <= branch & instValid;
			exMemRead  <= memRead & instValid;
			exMemWrite <= memWrite & instValid;
			exMemToReg <= memToReg & instValid;
			exAluSrc   <= aluSrc & instValid;
			exRegWrite <= regWrite & instValid;
			exJump     <= jump & instValid;
			exJumpJalr <= jumpJalr & instValid;
			exInAIsPc  <= inAIsPc & instValid;
		end
	end

	// payload half. it follows the slot even for a bubble.
	always_ff @(posedge clk) begin
		if (reset) begin
			exAluOp   <= ADD;
			exPc      <= '0;
			exRs1Data <= '0;
			exRs2Data <= '0;
			exImm     <= '0;
			exRd      <= '0;
			exFunct3  <= '0;
		end else if (flush || !stall) begin
			exAluOp   <= aluOp;
			exPc      <= pc;
			exRs1Data <= rs1Data;
			exRs2Data <= rs2Data;
			exImm     <= imm;
			exRd      <= rd;
			exFunct3  <= funct3;
		end
	end

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/10ps
`include "riscv_settings.svh"

module decodeStage
	import isaPkg::*;
	import controlPkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         instValid,
	input  instructionT                  instruction,
	input  logic [`XLEN-1:0]             pc,
	input  logic                         stall,
	input  logic                         flush,
	input  logic                         wbEnable,
	input  logic [$clog2(`REG_COUNT)-1:0] wbAddr,
	input  logic [`XLEN-1:0]             wbData,
	output logic                         exValid,
	output ctrlBitT                      exBranch,
	output ctrlBitT                      exMemRead,
	output ctrlBitT                      exMemWrite,
	output ctrlBitT                      exMemToReg,
	output ctrlBitT                      exAluSrc,
	output ctrlBitT                      exRegWrite,
	output ctrlBitT                      exJump,
	output ctrlBitT                      exJumpJalr,
	output ctrlBitT                      exInAIsPc,
	output aluOpT                        exAluOp,
	output logic [`XLEN-1:0]             exPc,
	output logic [`XLEN-1:0]             exRs1Data,
	output logic [`XLEN-1:0]             exRs2Data,
	output logic [`XLEN-1:0]             exImm,
	output logic [$clog2(`REG_COUNT)-1:0] exRd,
	output logic [2:0]                   exFunct3
);

	ctrlBitT          branch, memRead, memWrite, memToReg, aluSrc;
	ctrlBitT          regWrite, jump, jumpJalr, inAIsPc;
	aluCntrlT         aluCntrl;
	aluOpT            aluOp;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;

	mainControl u_mainControl (
		.opcode(instruction.rType.opcode), .branch(branch), .memRead(memRead),
		.memWrite(memWrite), .memToReg(memToReg), .aluSrc(aluSrc), .regWrite(regWrite),
		.jump(jump), .jumpJalr(jumpJalr), .inAIsPc(inAIsPc), .aluCntrl(aluCntrl)
	);

	// funct7 sits in the same bits as the upper immediate of shift-immediates.
	aluControl u_aluControl (
		.aluCntrl(aluCntrl), .funct3(instruction.rType.funct3),
		.funct7(instruction.rType.funct7), .aluOp(aluOp)
	);

	immGen u_immGen (.instruction(instruction), .imm(imm));

	regFile u_regFile (
		.clk(clk), .reset(reset), .rs1(instruction.rType.rs1), .rs2(instruction.rType.rs2),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .wbEnable(wbEnable), .wbAddr(wbAddr),
		.wbData(wbData)
	);

	idExRegister u_idExRegister (
		.clk(clk), .reset(reset), .stall(stall), .flush(flush), .instValid(instValid),
		.branch(branch), .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
		.aluSrc(aluSrc), .regWrite(regWrite), .jump(jump), .jumpJalr(jumpJalr),
		.inAIsPc(inAIsPc), .aluOp(aluOp), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.imm(imm), .rd(instruction.rType.rd), .funct3(instruction.rType.funct3),
		.exValid(exValid), .exBranch(exBranch), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exMemToReg(exMemToReg), .exAluSrc(exAluSrc),
		.exRegWrite(exRegWrite), .exJump(exJump), .exJumpJalr(exJumpJalr),
		.exInAIsPc(exInAIsPc), .exAluOp(exAluOp), .exPc(exPc), .exRs1Data(exRs1Data),
		.exRs2Data(exRs2Data), .exImm(exImm), .exRd(exRd), .exFunct3(exFunct3)
	);

endmodule

//--- test/decodeStage_properties.sv
`timescale 1ns/10ps
`include "riscv_settings.svh"

module decodeStageProperties (
	input logic                          clk,
	input logic                          reset,
	input logic                          stall,
	input logic                          flush,
	input logic                          exValid,
	input logic                          exBranch,
	input logic                          exMemRead,
	input logic                          exMemWrite,
	input logic                          exMemToReg,
	input logic                          exAluSrc,
	input logic                          exRegWrite,
	input logic                          exJump,
	input logic                          exJumpJalr,
	input logic                          exInAIsPc,
	input logic [3:0]                    exAluOp,
	input logic [`XLEN-1:0]              exPc,
	input logic [`XLEN-1:0]              exRs1Data,
	input logic [`XLEN-1:0]              exRs2Data,
	input logic [`XLEN-1:0]              exImm,
	input logic [$clog2(`REG_COUNT)-1:0] exRd,
	input logic [2:0]                    exFunct3
);

	logic [8:0] controlBits;
	int         failCount = 0;

	assign controlBits = {exBranch, exMemRead, exMemWrite, exMemToReg, exAluSrc,
		exRegWrite, exJump, exJumpJalr, exInAIsPc};

	// ------------------------------------------------------------------------
	// bubble and hold rules of the ID/EX register
	// ------------------------------------------------------------------------

	clearGivesBubble: assert property (
		@(posedge clk) (reset || flush) |=> (!exValid && controlBits == '0)
	) else begin
		$error("ex stage still valid or controlling after reset or flush");
		failCount++;
	end

	invalidHasNoControl: assert property (
		@(posedge clk) !exValid |-> controlBits == '0
	) else begin
		$error("control bit set on an invalid ex slot");
		failCount++;
	end

	// a stall without flush freezes the whole slot.
	holdWhileStalled: assert property (
		@(posedge clk) (!reset && stall && !flush) |=>
			($stable(exValid) && $stable(controlBits) && $stable(exAluOp)
			&& $stable({exPc, exRs1Data, exRs2Data, exImm}) && $stable({exRd, exFunct3}))
	) else begin
		$error("ex outputs changed during a stall");
		failCount++;
	end

endmodule

bind idExRegister decodeStageProperties u_decodeStageProperties (
	.clk(clk), .reset(reset), .stall(stall), .flush(flush), .exValid(exValid),
	.exBranch(exBranch), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
	.exMemToReg(exMemToReg), .exAluSrc(exAluSrc), .exRegWrite(exRegWrite),
	.exJump(exJump), .exJumpJalr(exJumpJalr), .exInAIsPc(exInAIsPc), .exAluOp(exAluOp),
	.exPc(exPc), .exRs1Data(exRs1Data), .exRs2Data(exRs2Data), .exImm(exImm),
	.exRd(exRd), .exFunct3(exFunct3)
);

//--- test/tb_decodeStage.sv
`timescale 1ns/10ps
`include "riscv_settings.svh"

module tb_decodeStage
	import isaPkg::*;
	import controlPkg::*;
();

	localparam int ADDR_W         = $clog2(`REG_COUNT);
	localparam int RESET_CYCLES   = 16;
	localparam int READ_CYCLES    = `REG_COUNT / 2;
	localparam int CONTROL_CYCLES = 300;
	localparam int IMM_CYCLES     = 200;
	localparam int WRITE_CYCLES   = 200;
	localparam int STALL_CYCLES   = 300;
	localparam int TOTAL_CYCLES   = RESET_CYCLES + 2 * READ_CYCLES + CONTROL_CYCLES
		+ IMM_CYCLES + WRITE_CYCLES + STALL_CYCLES;
	localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

	logic              clk;
	logic              reset;
	logic              instValid;
	logic [31:0]       instWord;
	logic [`XLEN-1:0]  pc;
	logic              stall;
	logic              flush;
	logic              wbEnable;
	logic [ADDR_W-1:0] wbAddr;
	logic [`XLEN-1:0]  wbData;
	logic              exValid;
	logic              exBranch;
	logic              exMemRead;
	logic              exMemWrite;
	logic              exMemToReg;
	logic              exAluSrc;
	logic              exRegWrite;
	logic              exJump;
	logic              exJumpJalr;
	logic              exInAIsPc;
	aluOpT             exAluOp;
	logic [`XLEN-1:0]  exPc;
	logic [`XLEN-1:0]  exRs1Data;
	logic [`XLEN-1:0]  exRs2Data;
	logic [`XLEN-1:0]  exImm;
	logic [ADDR_W-1:0] exRd;
	logic [2:0]        exFunct3;

	// reference model state.
	logic [`XLEN-1:0]  refRegs [`REG_COUNT];
	logic              expValid;
	logic [8:0]        expCtrl; // branch down to inAIsPc.
	aluOpT             expAluOp;
	logic [`XLEN-1:0]  expPc;
	logic [`XLEN-1:0]  expRs1;
	logic [`XLEN-1:0]  expRs2;
	logic [`XLEN-1:0]  expImm;
	logic [ADDR_W-1:0] expRd;
	logic [2:0]        expFunct3;
	logic [`XLEN-1:0]  pcCounter;
	logic [31:0]       lcgState;
	int                testErrors;
	int                totalErrors;
	int                propertyErrors;
	int                checkCount;
	int                testsRun;

	decodeStage u_decodeStage (
		.clk(clk), .reset(reset), .instValid(instValid), .instruction(instWord), .pc(pc),
		.stall(stall), .flush(flush), .wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData),
		.exValid(exValid), .exBranch(exBranch), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exMemToReg(exMemToReg), .exAluSrc(exAluSrc),
		.exRegWrite(exRegWrite), .exJump(exJump), .exJumpJalr(exJumpJalr),
		.exInAIsPc(exInAIsPc), .exAluOp(exAluOp), .exPc(exPc), .exRs1Data(exRs1Data),
		.exRs2Data(exRs2Data), .exImm(exImm), .exRd(exRd), .exFunct3(exFunct3)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// stimulus source and decode tables
	// ------------------------------------------------------------------------

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// immOnly keeps to the formats that carry an immediate.
	function automatic logic [31:0] randomWord(input bit immOnly);
		logic [31:0] r;
		logic [31:0] fields;
		logic [6:0]  opcode;
		int          sel;
		r      = nextRandom();
		fields = nextRandom();
		sel    = immOnly ? 1 + r[31:16] % 8 : r[31:16] % 11;
		case (sel)
			0:       opcode = R_FORMAT;
			1:       opcode = I_COMP_FORMAT;
			2:       opcode = I_LOAD_FORMAT;
			3:       opcode = I_JALR_FORMAT;
			4:       opcode = S_FORMAT;
			5:       opcode = B_FORMAT;
			6:       opcode = J_FORMAT;
			7:       opcode = U_FORMAT_LUI;
			8:       opcode = U_FORMAT_AUIPC;
			9:       opcode = SYSTEM_OPCODE;
			default: opcode = r[14:8]; // any pattern, legal or not.
		endcase
		return {fields[31:7], opcode};
	endfunction

	function automatic logic [8:0] expectedControls(input logic [6:0] opcode);
		case (opcode)
			R_FORMAT:       return 9'b000001000;
			I_COMP_FORMAT:  return 9'b000011000;
			I_LOAD_FORMAT:  return 9'b010111000;
			S_FORMAT:       return 9'b001010000;
			B_FORMAT:       return 9'b100000000;
			J_FORMAT:       return 9'b000001101;
			I_JALR_FORMAT:  return 9'b000001010;
			U_FORMAT_LUI:   return 9'b000011000;
			U_FORMAT_AUIPC: return 9'b000011001;
			default:        return 9'b000000000;
		endcase
	endfunction

	function automatic aluOpT arithOp(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  return alt ? SUB : ADD;
			3'b001:  return SLL;
			3'b010:  return SLT;
			3'b011:  return SLTU;
			3'b100:  return XOR;
			3'b101:  return alt ? SRA : SRL;
			3'b110:  return OR;
			default: return AND;
		endcase
	endfunction

	function automatic aluOpT expectedAluOp(input logic [31:0] word);
		logic [2:0] funct3;
		funct3 = word[14:12];
		case (word[6:0])
			I_LOAD_FORMAT, S_FORMAT, J_FORMAT, I_JALR_FORMAT, U_FORMAT_AUIPC: return ADD;
			U_FORMAT_LUI: return PASS_B;
			I_COMP_FORMAT: return arithOp(funct3, word[30] && funct3 == 3'b101);
			B_FORMAT: begin
				case (funct3)
					3'b001:  return BR_NE;
					3'b100:  return BR_LT;
					3'b101:  return BR_GE;
					3'b110:  return BR_LTU;
					3'b111:  return BR_GE;
					default: return BR_EQ;
				endcase
			end
			default: return arithOp(funct3, word[30]); // unknown words decode as R.
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] expectedImm(input logic [31:0] w);
		case (w[6:0])
			I_COMP_FORMAT, I_LOAD_FORMAT, I_JALR_FORMAT: return {{20{w[31]}}, w[31:20]};
			S_FORMAT:     return {{20{w[31]}}, w[31:25], w[11:7]};
			B_FORMAT:     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			U_FORMAT_LUI, U_FORMAT_AUIPC: return {w[31:12], 12'b0};
			J_FORMAT:     return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:      return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] readModel(input logic [ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wbEnable && wbAddr == addr)
			return wbData; // write-first.
		return refRegs[addr];
	endfunction

	// ------------------------------------------------------------------------
	// model update, drive and compare
	// ------------------------------------------------------------------------

	task automatic resetModel();
		for (int i = 0; i < `REG_COUNT; i++)
			refRegs[i] = '0;
		expValid  = 1'b0;
		expCtrl   = '0;
		expAluOp  = ADD;
		expPc     = '0;
		expRs1    = '0;
		expRs2    = '0;
		expImm    = '0;
		expRd     = '0;
		expFunct3 = '0;
	endtask

	task automatic predictNext();
		if (flush || !stall) begin // a bubble still carries the new payload.
			expAluOp  = expectedAluOp(instWord);
			expPc     = pc;
			expRs1    = readModel(instWord[19:15]);
			expRs2    = readModel(instWord[24:20]);
			expImm    = expectedImm(instWord);
			expRd     = instWord[11:7];
			expFunct3 = instWord[14:12];
		end
		if (flush) begin
			expValid = 1'b0;
			expCtrl  = '0;
		end else if (!stall) begin
			expValid = instValid;
			expCtrl  = instValid ? expectedControls(instWord[6:0]) : 9'b0;
		end
	endtask

	task automatic checkOutputs();
		logic [8:0] ctrlNow;
		ctrlNow = {exBranch, exMemRead, exMemWrite, exMemToReg, exAluSrc, exRegWrite,
			exJump, exJumpJalr, exInAIsPc};
		checkCount++;
		assert (exValid === expValid && ctrlNow === expCtrl) else begin
			$display("ERR %0t: valid %b control %b, expected valid %b control %b",
				$time, exValid, ctrlNow, expValid, expCtrl);
			testErrors++;
		end
		assert (exAluOp === expAluOp) else begin
			$display("ERR %0t: aluOp %0d, expected %0d", $time, exAluOp, expAluOp);
			testErrors++;
		end
		assert (exImm === expImm) else begin
			$display("ERR %0t: imm %h, expected %h", $time, exImm, expImm);
			testErrors++;
		end
		assert (exRs1Data === expRs1 && exRs2Data === expRs2) else begin
			$display("ERR %0t: operands %h %h, expected %h %h",
				$time, exRs1Data, exRs2Data, expRs1, expRs2);
			testErrors++;
		end
		assert (exPc === expPc && exRd === expRd && exFunct3 === expFunct3) else begin
			$display("ERR %0t: pc %h rd %0d funct3 %b, expected pc %h rd %0d funct3 %b",
				$time, exPc, exRd, exFunct3, expPc, expRd, expFunct3);
			testErrors++;
		end
	endtask

	// drive at edge plus 2 ns, compare at the next edge plus 1 ns.
	task automatic runCycle(input logic valid, input logic [31:0] word, input logic stallIn,
			input logic flushIn, input logic wbEn, input logic [ADDR_W-1:0] wbA,
			input logic [`XLEN-1:0] wbD);
		instValid = valid;
		instWord  = word;
		pc        = pcCounter;
		stall     = stallIn;
		flush     = flushIn;
		wbEnable  = wbEn;
		wbAddr    = wbA;
		wbData    = wbD;
		pcCounter = pcCounter + 4;
		predictNext();
		if (wbEn && wbA != '0)
			refRegs[wbA] = wbD;
		@(posedge clk);
		#1;
		checkOutputs();
		#1;
	endtask

	task automatic finishTest(input string name, input int cycles);
		$display("test %s: %0d cycles, %0d errors", name, cycles, testErrors);
		totalErrors += testErrors;
		testErrors = 0;
		testsRun++;
	endtask

	task automatic readAllRegisters();
		logic [31:0] word;
		for (int i = 0; i < READ_CYCLES; i++) begin
			word        = randomWord(1'b0);
			word[6:0]   = R_FORMAT;
			word[19:15] = ADDR_W'(2 * i);
			word[24:20] = ADDR_W'(2 * i + 1);
			runCycle(1'b1, word, 1'b0, 1'b0, 1'b0, '0, '0);
		end
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------

	task automatic controlTest(input string name, input bit immOnly, input int cycles);
		for (int i = 0; i < cycles; i++)
			runCycle(1'b1, randomWord(immOnly), 1'b0, 1'b0, 1'b0, '0, '0);
		finishTest(name, cycles);
	endtask

	task automatic regFileTest();
		logic [31:0] r;
		logic [31:0] word;
		for (int i = 0; i < WRITE_CYCLES; i++) begin
			r         = nextRandom();
			word      = randomWord(1'b0);
			word[6:0] = R_FORMAT;
			if (r[24])
				word[19:15] = r[29:25]; // read the address being written.
			if (r[23])
				word[24:20] = r[29:25];
			runCycle(1'b1, word, 1'b0, 1'b0, r[31:30] != 2'b00, r[29:25], nextRandom());
		end
		readAllRegisters();
		finishTest("regFile", WRITE_CYCLES + READ_CYCLES);
	endtask

	task automatic stallFlushTest();
		logic [31:0] r;
		for (int i = 0; i < STALL_CYCLES; i++) begin
			r = nextRandom();
			runCycle(r[26:24] != 3'b000, randomWord(1'b0), r[31:30] == 2'b00,
				r[29:27] == 3'b000, r[23], r[22:18], nextRandom());
		end
		finishTest("stallFlush", STALL_CYCLES);
	endtask

	initial begin
		clk            = 1'b0;
		reset          = 1'b1;
		instValid      = 1'b0;
		instWord       = '0;
		pc             = '0;
		stall          = 1'b0;
		flush          = 1'b0;
		wbEnable       = 1'b0;
		wbAddr         = '0;
		wbData         = '0;
		lcgState       = 32'd99049;
		pcCounter      = 32'h0000_1000;
		testErrors     = 0;
		totalErrors    = 0;
		propertyErrors = 0;
		checkCount     = 0;
		testsRun       = 0;
		resetModel();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;

		checkOutputs(); // straight out of reset.
		readAllRegisters();
		finishTest("reset", READ_CYCLES);
		controlTest("control", 1'b0, CONTROL_CYCLES);
		controlTest("immediate", 1'b1, IMM_CYCLES);
		regFileTest();
		stallFlushTest();

		propertyErrors = u_decodeStage.u_idExRegister.u_decodeStageProperties.failCount;
		$display("%0d tests, %0d checks, %0d errors, %0d property failures",
			testsRun, checkCount, totalErrors, propertyErrors);
		if (totalErrors == 0 && propertyErrors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(TOTAL_CYCLES * 20 + 1000);
		$display("timeout: the tests did not finish in the expected time");
		$display("sim failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+hw
hw/isaPkg.sv
hw/controlPkg.sv
hw/mainControl.sv
hw/aluControl.sv
hw/immGen.sv
hw/regFile.sv
hw/idExRegister.sv
hw/decodeStage.sv
test/decodeStage_properties.sv
test/tb_decodeStage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/isaPkg.sv
      - hw/controlPkg.sv
      - hw/mainControl.sv
      - hw/aluControl.sv
      - hw/immGen.sv
      - hw/regFile.sv
      - hw/idExRegister.sv
      - hw/decodeStage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/decodeStage_properties.sv
      - test/tb_decodeStage.sv
